/* hw/zx_pkg.sv */
// Spectrum memory and port definitions
`default_nettype none

package zx_pkg;

	// ====================================================================
	// Width types
	// ====================================================================
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [20:0] mem_addr_t;  // ROM space at 101, RAM below
	typedef logic [5:0]  ram_bank_t;  // 3 extended bits + 3 from 7FFD
	typedef logic [3:0]  rom_page_t;
	typedef logic [4:0]  kbd_cols_t;  // Active low, one bit per key
	typedef logic [4:0]  joy_t;       // Fire, up, down, left, right

	// Memory model, latched at reset
	typedef enum logic [2:0] {
		MACH_128   = 3'd0,  // 128K and +2
		MACH_P1024 = 3'd1,
		MACH_PROFI = 3'd2,
		MACH_48    = 3'd3,
		MACH_PLUS3 = 3'd4   // +2A and +3
	} machine_t;

	typedef enum logic [2:0] {
		JOY_KEMPSTON   = 3'd0,
		JOY_SINCLAIR1  = 3'd1,
		JOY_SINCLAIR2  = 3'd2,
		JOY_SINCLAIR12 = 3'd3,
		JOY_CURSOR     = 3'd4
	} joy_mode_t;

	// ====================================================================
	// Buses and state
	// ====================================================================
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     dout;    // Data driven by the CPU
		logic      mreq_n;
		logic      iorq_n;
		logic      rd_n;
		logic      wr_n;
		logic      m1_n;
	} cpu_bus_t;

	typedef struct packed {
		logic io_wr_pulse;  // One cycle per I/O write
		logic io_rd;
		logic mem_rd;
		logic mem_wr;
	} io_strobes_t;

	typedef struct packed {
		byte_t      page_reg;   // 7FFD
		byte_t      plus3_reg;  // 1FFD
		byte_t      p1024_reg;  // EFF7
		logic [2:0] bank_ext;   // Upper RAM bank bits
		logic       is_48;
		logic       is_p1024;
		logic       is_profi;
		logic       is_plus3;
		logic       lock;       // 7FFD and 1FFD frozen
	} paging_t;

	// ====================================================================
	// Constants
	// ====================================================================
	localparam cpu_addr_t  PORT_PROFI_EXT = 16'hDFFD;
	localparam ram_bank_t  BANK_SCREEN    = 6'd5;
	localparam ram_bank_t  BANK_MID       = 6'd2;
	localparam logic [2:0] ROM_SPACE      = 3'b101;
	localparam logic [5:0] KEMPSTON_LOW   = 6'h1F;

endpackage

`default_nettype wire

/* hw/bus_decode.sv */
// CPU bus strobe decoder
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::cpu_bus_t    bus,
	output zx_pkg::io_strobes_t strobes
);
	import zx_pkg::*;

	logic io_wr;
	logic io_rd;
	logic io_wr_prev;  // Write level seen at the last edge

	// ====================================================================
	// I/O cycles
	// ====================================================================

	// M1 low with IORQ is an interrupt acknowledge, not a port access
	assign io_wr = ~bus.iorq_n & ~bus.wr_n & bus.m1_n;
	assign io_rd = ~bus.iorq_n & ~bus.rd_n & bus.m1_n;

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_wr_prev <= 1'b0;
		else
			io_wr_prev <= io_wr;
	end

	// ====================================================================
	// Outputs
	// ====================================================================
	always_comb begin
		strobes.io_wr_pulse = io_wr & ~io_wr_prev;  // First cycle only
		strobes.io_rd       = io_rd;
		strobes.mem_rd      = ~bus.mreq_n & ~bus.rd_n;
		strobes.mem_wr      = ~bus.mreq_n & ~bus.wr_n;
	end

endmodule

`default_nettype wire

/* hw/paging_regs.sv */
// Memory paging registers
`timescale 1ns/1ps
`default_nettype none

module paging_regs (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx_pkg::cpu_bus_t    bus,
	input  zx_pkg::io_strobes_t strobes,
	input  zx_pkg::machine_t    machine,
	output zx_pkg::paging_t     paging
);
	import zx_pkg::*;

	byte_t      page_reg;
	byte_t      plus3_reg;
	byte_t      p1024_reg;
	logic [2:0] bank_ext;
	logic       is_48;
	logic       is_p1024;
	logic       is_profi;
	logic       is_plus3;
	logic       lock;
	logic       page_write;
	logic       plus3_write;
	logic       eff7_write;
	logic       dffd_write;

	// ====================================================================
	// Lock and port decode
	// ====================================================================

	// Pentagon keeps 7FFD open while EFF7 bit 2 is clear
	assign lock = is_48
		| (~is_p1024 & page_reg[5])
		| (is_p1024 & p1024_reg[2] & page_reg[5]);

	// 7FFD, the +3 also needs A14 high
	assign page_write = ~bus.addr[15] & ~bus.addr[1]
		& (bus.addr[14] | ~is_plus3) & ~lock;

	// 1FFD
	assign plus3_write = is_plus3 & (bus.addr[15:13] == 3'b000) & bus.addr[12]
		& ~bus.addr[1] & ~lock;

	assign eff7_write = is_p1024 & (bus.addr[15:13] == 3'b111) & ~bus.addr[12]
		& ~bus.addr[3];
	assign dffd_write = is_profi & (bus.addr == PORT_PROFI_EXT);

	// ====================================================================
	// Registers
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			is_48     <= (machine == MACH_48);
			is_p1024  <= (machine == MACH_P1024);
			is_profi  <= (machine == MACH_PROFI);
			is_plus3  <= (machine == MACH_PLUS3);
			page_reg  <= '0;
			plus3_reg <= '0;
			p1024_reg <= '0;
			bank_ext  <= '0;
		end else if (strobes.io_wr_pulse) begin
			if (page_write) begin
				page_reg <= bus.dout;
				// Pentagon 1024 upper bank bits
				if (is_p1024 && !p1024_reg[2])
					bank_ext <= {bus.dout[5], bus.dout[7:6]};
			end else if (plus3_write) begin
				plus3_reg <= bus.dout;
			end

			if (dffd_write)
				bank_ext <= bus.dout[2:0];  // Profi extension
			if (eff7_write)
				p1024_reg <= bus.dout;
		end
	end

	always_comb begin
		paging.page_reg  = page_reg;
		paging.plus3_reg = plus3_reg;
		paging.p1024_reg = p1024_reg;
		paging.bank_ext  = bank_ext;
		paging.is_48     = is_48;
		paging.is_p1024  = is_p1024;
		paging.is_profi  = is_profi;
		paging.is_plus3  = is_plus3;
		paging.lock      = lock;
	end

endmodule

`default_nettype wire

/* hw/addr_mapper.sv */
// CPU to physical address mapper
`timescale 1ns/1ps
`default_nettype none

module addr_mapper (
	input  zx_pkg::cpu_bus_t    bus,
	input  zx_pkg::io_strobes_t strobes,
	input  zx_pkg::paging_t     paging,
	output zx_pkg::mem_addr_t   mem_addr,
	output logic                ram_rd,
	output logic                ram_we
);
	import zx_pkg::*;

	rom_page_t  rom_page;
	ram_bank_t  special_bank;
	logic [1:0] quarter;
	logic       special;
	logic       mode_any;   // Either layout bit set
	logic       mode_both;

	assign quarter   = bus.addr[15:14];
	assign special   = paging.plus3_reg[0];  // +3 all-RAM layouts
	assign mode_any  = |paging.plus3_reg[2:1];
	assign mode_both = &paging.plus3_reg[2:1];

	// ====================================================================
	// ROM page
	// ====================================================================
	always_comb begin
		if (paging.is_plus3)
			rom_page = {2'b10, paging.plus3_reg[2], paging.page_reg[4]};
		else
			rom_page = {paging.is_48, 2'b11, paging.is_48 | paging.page_reg[4]};
	end

	// ====================================================================
	// Special layouts
	// 0-1-2-3, 4-5-6-7, 4-5-6-3, 4-7-6-3
	// ====================================================================
	always_comb begin
		case (quarter)
			2'd0:    special_bank = {3'b000, mode_any, 2'b00};
			2'd1:    special_bank = {3'b000, mode_any, mode_both, 1'b1};
			2'd2:    special_bank = {3'b000, mode_any, 2'b10};
			default: special_bank = {3'b000, ~paging.plus3_reg[2] & paging.plus3_reg[1], 2'b11};
		endcase
	end

	always_comb begin
		if (special) begin
			mem_addr = {1'b0, special_bank, bus.addr[13:0]};
		end else begin
			case (quarter)
				2'd0:    mem_addr = {ROM_SPACE, rom_page, bus.addr[13:0]};
				2'd1:    mem_addr = {1'b0, BANK_SCREEN, bus.addr[13:0]};
				2'd2:    mem_addr = {1'b0, BANK_MID, bus.addr[13:0]};
				default: mem_addr = {1'b0, paging.bank_ext, paging.page_reg[2:0],
					bus.addr[13:0]};
			endcase
		end
	end

	// ROM is read only outside the special layouts
	assign ram_rd = strobes.mem_rd;
	assign ram_we = strobes.mem_wr & (special | (quarter != 2'd0));

endmodule

`default_nettype wire

/* hw/io_ports.sv */
// ULA, joystick ports and read mux
`timescale 1ns/1ps
`default_nettype none

module io_ports (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx_pkg::cpu_bus_t    bus,
	input  zx_pkg::io_strobes_t strobes,
	input  zx_pkg::paging_t     paging,
	input  zx_pkg::joy_mode_t   joy_mode,
	input  zx_pkg::joy_t        joy0,
	input  zx_pkg::joy_t        joy1,
	input  zx_pkg::kbd_cols_t   key_cols,
	input  zx_pkg::byte_t       ram_dout,
	output zx_pkg::byte_t       cpu_din,
	output logic [2:0]          border,
	output logic                ear,
	output logic                mic,
	output logic                screen_page
);
	import zx_pkg::*;

	logic [4:0] s1_keys;   // Keys 6 to 0, pressed high
	logic [4:0] s2_keys;   // Keys 1 to 5
	logic [4:0] cur_keys;  // Cursor keys on the 6 to 0 row
	logic       cur_left;  // Key 5
	logic       cursor_on;
	kbd_cols_t  joy_cols;
	kbd_cols_t  merged_cols;
	byte_t      kempston;

	// ====================================================================
	// ULA port
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= '0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (strobes.io_wr_pulse && !bus.addr[0]) begin
			border <= bus.dout[2:0];
			mic    <= bus.dout[3];
			ear    <= bus.dout[4];
		end
	end

	assign screen_page = paging.page_reg[3];

	// ====================================================================
	// Joystick to keyboard
	// ====================================================================
	always_comb begin
		s1_keys = '0;
		s2_keys = '0;
		if (joy_mode == JOY_SINCLAIR1 || joy_mode == JOY_SINCLAIR12)
			s1_keys = {joy0[1:0], joy0[2], joy0[3], joy0[4]};
		if (joy_mode == JOY_SINCLAIR1)  // Both sticks on one port
			s1_keys = s1_keys | {joy1[1:0], joy1[2], joy1[3], joy1[4]};
		if (joy_mode == JOY_SINCLAIR2 || joy_mode == JOY_SINCLAIR12)
			s2_keys = {joy1[4:2], joy1[0], joy1[1]};
		if (joy_mode == JOY_SINCLAIR2)
			s2_keys = s2_keys | {joy0[4:2], joy0[0], joy0[1]};
	end

	assign cursor_on = (joy_mode == JOY_CURSOR);
	assign cur_keys  = {5{cursor_on}}
		& ({joy0[2], joy0[3], joy0[0], 1'b0, joy0[4]}
		| {joy1[2], joy1[3], joy1[0], 1'b0, joy1[4]});
	assign cur_left  = cursor_on & (joy0[1] | joy1[1]);

	// A12 and A11 select the half rows
	assign joy_cols = ({5{bus.addr[12]}} | ~(s1_keys | cur_keys))
		& ({5{bus.addr[11]}} | ~(s2_keys | {cur_left, 4'b0000}));
	assign merged_cols = key_cols & joy_cols;

	assign kempston = (joy_mode == JOY_KEMPSTON) ? {3'b000, joy0 | joy1} : 8'h00;

	// ====================================================================
	// CPU read data
	// ====================================================================
	always_comb begin
		if (strobes.mem_rd)
			cpu_din = ram_dout;
		else if (strobes.io_rd && bus.addr[5:0] == KEMPSTON_LOW)
			cpu_din = kempston;
		else if (strobes.io_rd && !bus.addr[0])
			cpu_din = {3'b111, merged_cols};  // Tape input idles high
		else
			cpu_din = 8'hFF;
	end

endmodule

`default_nettype wire

/* hw/zx_mem_io.sv */
// Spectrum memory and I/O core
`timescale 1ns/1ps
`default_nettype none

module zx_mem_io (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::cpu_bus_t  bus,
	input  zx_pkg::machine_t  machine,
	input  zx_pkg::joy_mode_t joy_mode,
	input  zx_pkg::joy_t      joy0,
	input  zx_pkg::joy_t      joy1,
	input  zx_pkg::kbd_cols_t key_cols,
	input  zx_pkg::byte_t     ram_dout,
	output zx_pkg::mem_addr_t mem_addr,
	output logic              ram_rd,
	output logic              ram_we,
	output zx_pkg::byte_t     cpu_din,
	output logic [2:0]        border,
	output logic              ear,
	output logic              mic,
	output logic              screen_page
);
	import zx_pkg::*;

	io_strobes_t io_strobes;
	paging_t     paging;

	bus_decode u_bus_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.strobes (io_strobes)
	);

	paging_regs u_paging_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.strobes (io_strobes),
		.machine (machine),
		.paging  (paging)
	);

	addr_mapper u_addr_mapper (
		.bus      (bus),
		.strobes  (io_strobes),
		.paging   (paging),
		.mem_addr (mem_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we)
	);

	io_ports u_io_ports (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.strobes     (io_strobes),
		.paging      (paging),
		.joy_mode    (joy_mode),
		.joy0        (joy0),
		.joy1        (joy1),
		.key_cols    (key_cols),
		.ram_dout    (ram_dout),
		.cpu_din     (cpu_din),
		.border      (border),
		.ear         (ear),
		.mic         (mic),
		.screen_page (screen_page)
	);

endmodule

`default_nettype wire

/* test/zx_tb_vectors.svh */
// Bus operation table
// Columns: op, machine, joystick mode, joy0, key columns, address, data,
// expected mem_addr, ram_we, cpu_din, screen_page and port FE bits (ear, mic, border)

task automatic fill_table();
	// 128K banking and lock
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0000, 8'h00, 21'h158000, 0, 8'h00, 0, 0);
	add_row(OP_MWR, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0123, 8'h00, 21'h158123, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h4000, 8'h00, 21'h014000, 0, 8'h00, 0, 0);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h8001, 8'h00, 21'h008001, 0, 8'h00, 0, 0);
	add_row(OP_IOW, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h1B, 21'h000000, 0, 8'hFF, 1, 0);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC010, 8'h00, 21'h00C010, 0, 8'h00, 1, 0);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0000, 8'h00, 21'h15C000, 0, 8'h00, 1, 0);
	add_row(OP_MWR, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h00C000, 1, 8'hFF, 1, 0);
	add_row(OP_IOW, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h26, 21'h000000, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h018000, 0, 8'h00, 0, 0);
	add_row(OP_IOW, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h01, 21'h000000, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h018000, 0, 8'h00, 0, 0);
	// 48K ignores 7FFD
	add_row(OP_MRD, MACH_48, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0000, 8'h00, 21'h17C000, 0, 8'h00, 0, 0);
	add_row(OP_IOW, MACH_48, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h03, 21'h000000, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_48, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h000000, 0, 8'h00, 0, 0);
	// Pentagon 1024 and Profi extended banks
	add_row(OP_IOW, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'hE1, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC004, 8'h00, 21'h0E4004, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h42, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC004, 8'h00, 21'h028004, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hEFF7, 8'h04, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_IOW, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'hE3, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_IOW, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h02, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_P1024, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC004, 8'h00, 21'h02C004, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_PROFI, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hDFFD, 8'h05, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_IOW, MACH_PROFI, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h03, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_PROFI, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h0AC000, 0, 8'h0, 0, 0);
	// +3 ROM pages and all-RAM layouts
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0000, 8'h00, 21'h160000, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h1FFD, 8'h04, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_IOW, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h7FFD, 8'h10, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0000, 8'h00, 21'h16C000, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h1FFD, 8'h01, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MWR, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0005, 8'h00, 21'h000005, 1, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h00C000, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h1FFD, 8'h03, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h0000, 8'h00, 21'h010000, 0, 8'h0, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h01C000, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h1FFD, 8'h05, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h4000, 8'h00, 21'h014000, 0, 8'h0, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'hC000, 8'h00, 21'h00C000, 0, 8'h0, 0, 0);
	add_row(OP_IOW, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h1FFD, 8'h07, 21'h0, 0, 8'hFF, 0, 0);
	add_row(OP_MRD, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h4000, 8'h00, 21'h01C000, 0, 8'h0, 0, 0);
	add_row(OP_MWR, MACH_PLUS3, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h8000, 8'h00, 21'h018000, 1, 8'hFF, 0, 0);
	// ULA write and port reads
	add_row(OP_IOW, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h00FE, 8'h1D, 21'h0, 0, 8'hFF, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1A, 16'h00FE, 8'h00, 21'h0, 0, 8'hFA, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_KEMPSTON, 5'h15, 5'h1F, 16'h001F, 8'h00, 21'h0, 0, 8'h15, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_SINCLAIR1, 5'h15, 5'h1F, 16'h001F, 8'h00, 21'h0, 0, 8'h00, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_SINCLAIR1, 5'h10, 5'h1F, 16'hEFFE, 8'h00, 21'h0, 0, 8'hFE, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_SINCLAIR2, 5'h02, 5'h1F, 16'hF7FE, 8'h00, 21'h0, 0, 8'hFE, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_CURSOR, 5'h08, 5'h1F, 16'hE7FE, 8'h00, 21'h0, 0, 8'hF7, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_CURSOR, 5'h02, 5'h1F, 16'hF7FE, 8'h00, 21'h0, 0, 8'hEF, 0, 5'h1D);
	add_row(OP_IOR, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h00FD, 8'h00, 21'h0, 0, 8'hFF, 0, 5'h1D);
	add_row(OP_MRD, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h4123, 8'h00, 21'h014123, 0, 8'h0, 0, 5'h1D);
	add_row(OP_IOW, MACH_128, JOY_KEMPSTON, 5'h00, 5'h1F, 16'h00FE, 8'h02, 21'h0, 0, 8'hFF, 0, 5'h02);
endtask

/* test/zx_mem_io_tb.sv */
// Memory and I/O core testbench
`timescale 1ns/1ps
`default_nettype none

module zx_mem_io_tb;
	import zx_pkg::*;

	localparam int OP_MRD = 0;
	localparam int OP_MWR = 1;
	localparam int OP_IOW = 2;
	localparam int OP_IOR = 3;
	localparam int RESET_CYCLES = 10;

	typedef struct packed {
		logic [1:0] op;
		machine_t   mach;
		joy_mode_t  mode;
		joy_t       joy;
		kbd_cols_t  keys;
		cpu_addr_t  addr;
		byte_t      data;
		mem_addr_t  exp_addr;
		logic       exp_we;
		byte_t      exp_din;
		logic       exp_screen;
		logic [4:0] exp_ula;    // Ear, mic and border as in port FE
	} row_t;

	logic      clk_sys = 1'b0;
	logic      reset;
	cpu_bus_t  bus;
	machine_t  machine;
	joy_mode_t joy_mode;
	joy_t      joy0;
	joy_t      joy1;
	kbd_cols_t key_cols;
	byte_t     ram_dout;
	mem_addr_t mem_addr;
	logic      ram_rd;
	logic      ram_we;
	byte_t     cpu_din;
	logic [2:0] border;
	logic      ear;
	logic      mic;
	logic      screen_page;

	row_t        rows[$];
	logic [31:0] lfsr = 32'h006d36df;
	int          cycles = 0;
	int          limit = 0;

	zx_mem_io uut (
		.clk_sys(clk_sys), .reset(reset), .bus(bus), .machine(machine),
		.joy_mode(joy_mode), .joy0(joy0), .joy1(joy1), .key_cols(key_cols),
		.ram_dout(ram_dout), .mem_addr(mem_addr), .ram_rd(ram_rd), .ram_we(ram_we),
		.cpu_din(cpu_din), .border(border), .ear(ear), .mic(mic),
		.screen_page(screen_page)
	);

	always #50 clk_sys = ~clk_sys;

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("Timeout: the test did not finish within %0d cycles", limit);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	end

	task automatic add_row(input int op, input machine_t mach, input joy_mode_t mode,
		input joy_t joy, input kbd_cols_t keys, input cpu_addr_t addr, input byte_t data,
		input mem_addr_t exp_addr, input logic exp_we, input byte_t exp_din,
		input logic exp_screen, input logic [4:0] exp_ula);
		row_t r;
		r = '{op[1:0], mach, mode, joy, keys, addr, data, exp_addr, exp_we, exp_din,
			exp_screen, exp_ula};
		rows.push_back(r);
	endtask

	`include "zx_tb_vectors.svh"

	// Taps 32, 22, 2, 1; one step per bit
	function automatic byte_t next_byte();
		byte_t b;
		for (int i = 0; i < 8; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic bus_idle();
		bus.mreq_n = 1'b1;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		bus.m1_n   = 1'b1;
	endtask

	task automatic apply_reset(input machine_t mach);
		machine = mach;
		reset   = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset   = 1'b0;
	endtask

	initial begin
		int       resets;
		row_t     r;
		byte_t    rnd;
		machine_t last;

		reset    = 1'b1;
		bus      = '0;
		bus_idle();
		machine  = MACH_128;
		joy_mode = JOY_KEMPSTON;
		joy0     = '0;
		joy1     = '0;
		key_cols = '1;
		ram_dout = '0;

		fill_table();
		resets = 1;
		for (int i = 1; i < rows.size(); i++)
			if (rows[i].mach != rows[i-1].mach)
				resets++;
		limit = rows.size() * 4 + resets * RESET_CYCLES + 100;

		// ====================================================================
		// Vector loop
		// ====================================================================
		@(negedge clk_sys);
		foreach (rows[i]) begin
			r = rows[i];
			if (i == 0 || r.mach != last)
				apply_reset(r.mach);  // New model needs a fresh latch
			last = r.mach;

			joy_mode = r.mode;
			joy0     = r.joy;
			key_cols = r.keys;
			rnd = next_byte();
			ram_dout = rnd;
			bus.addr = r.addr;
			rnd = next_byte();
			bus.dout = (r.op == OP_IOW) ? r.data : rnd;  // Memory data is don't care
			bus.mreq_n = !(r.op == OP_MRD || r.op == OP_MWR);
			bus.iorq_n = !(r.op == OP_IOW || r.op == OP_IOR);
			bus.rd_n   = !(r.op == OP_MRD || r.op == OP_IOR);
			bus.wr_n   = !(r.op == OP_MWR || r.op == OP_IOW);
			repeat (2) @(negedge clk_sys);

			if (r.op == OP_MRD || r.op == OP_MWR)
				check("mem_addr", mem_addr, r.exp_addr);
			check("ram_rd", ram_rd, r.op == OP_MRD);
			check("ram_we", ram_we, r.exp_we);
			check("cpu_din", cpu_din, (r.op == OP_MRD) ? ram_dout : r.exp_din);
			check("screen_page", screen_page, r.exp_screen);
			check("border", border, r.exp_ula[2:0]);
			check("mic", mic, r.exp_ula[3]);
			check("ear", ear, r.exp_ula[4]);

			bus_idle();
			@(negedge clk_sys);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
hw/zx_pkg.sv
hw/bus_decode.sv
hw/paging_regs.sv
hw/addr_mapper.sv
hw/io_ports.sv
hw/zx_mem_io.sv
test/zx_mem_io_tb.sv
